/* hdl/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;
  localparam int num_regs = 32;
  localparam int imm_width = 16;

  ////////////////////////////////////////////////////////////
  // instruction fields
  ////////////////////////////////////////////////////////////
  localparam int op_msb = 31;
  localparam int op_lsb = 26;
  localparam int rs_msb = 25;
  localparam int rs_lsb = 21;
  localparam int rt_msb = 20;
  localparam int rt_lsb = 16;
  localparam int rd_msb = 15;
  localparam int rd_lsb = 11;
  localparam int imm_msb = 15;
  localparam int imm_lsb = 0;

  typedef logic [31:0] inst_t;

  // anything not listed decodes as a nop
  typedef enum logic [5:0] {
    op_nop  = 6'h00,
    op_add  = 6'h01,
    op_sub  = 6'h02,
    op_and  = 6'h03,
    op_or   = 6'h04,
    op_xor  = 6'h05,
    op_slt  = 6'h06,
    op_addi = 6'h08,
    op_sw   = 6'h2b
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_t;

  // operand source in EX
  typedef enum logic {
    fwd_reg,
    fwd_wb
  } fwd_sel_t;

endpackage

`default_nettype wire

/* hdl/fetch_unit.sv */
`default_nettype none

module fetch_unit import pipe_pkg::*; #(
  parameter logic [xlen-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            arst_n,
  output logic            ibus_cyc,
  output logic            ibus_stb,
  output logic [xlen-1:0] ibus_adr,
  input  logic            ibus_ack,
  input  inst_t           ibus_dat_i,
  input  logic            take,
  output inst_t           inst,
  output logic            inst_valid
);

  logic [xlen-1:0] pc;
  logic            buf_valid;
  inst_t           buf_inst;

  // the buffer doubles as the ID stage
  assign inst       = buf_inst;
  assign inst_valid = buf_valid;
  assign ibus_adr   = pc;

  ////////////////////////////////////////////////////////////
  // bus master
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ibus_cyc <= 1'b0;
      ibus_stb <= 1'b0;
      pc       <= RESET_PC;
    end else if (ibus_cyc) begin
      if (ibus_ack) begin
        ibus_cyc <= 1'b0;
        ibus_stb <= 1'b0;
        pc       <= pc + xlen'(4);
      end
    end else if (!buf_valid || take) begin
      // room for one more word
      ibus_cyc <= 1'b1;
      ibus_stb <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // instruction buffer
  ////////////////////////////////////////////////////////////
  // ack only lands while the buffer is empty
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      buf_valid <= 1'b0;
    end else if (ibus_cyc && ibus_ack) begin
      buf_valid <= 1'b1;
    end else if (take) begin
      buf_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ibus_cyc && ibus_ack) begin
      buf_inst <= ibus_dat_i;
    end
  end

  a_stb_in_cyc : assert property (
    @(posedge clk) disable iff (!arst_n)
    ibus_stb |-> ibus_cyc
  );

  // request held until the slave answers
  a_req_stable : assert property (
    @(posedge clk) disable iff (!arst_n)
    ibus_stb && !ibus_ack |=> ibus_stb && $stable(ibus_adr)
  );

endmodule

`default_nettype wire

/* hdl/pipe_control.sv */
`default_nettype none

module pipe_control import pipe_pkg::*; (
  input  logic                      clk,
  input  logic                      arst_n,
  input  inst_t                     inst,
  input  logic                      inst_valid,
  input  logic                      store_done,
  output logic                      take,
  output logic [reg_addr_width-1:0] rs_addr,
  output logic [reg_addr_width-1:0] rt_addr,
  output alu_op_t                   alu_op,
  output logic                      use_imm,
  output logic [imm_width-1:0]      imm,
  output fwd_sel_t                  fwd_a,
  output fwd_sel_t                  fwd_b,
  output logic                      advance,
  output logic [reg_addr_width-1:0] wb_rd,
  output logic                      wb_we,
  output logic                      wb_is_store
);

  opcode_t                   id_op;
  alu_op_t                   dec_alu_op;
  logic                      dec_use_imm;
  logic                      dec_we;
  logic                      dec_store;
  logic [reg_addr_width-1:0] dec_dst;

  logic                      ex_valid;
  logic [reg_addr_width-1:0] ex_rs;
  logic [reg_addr_width-1:0] ex_rt;
  logic [reg_addr_width-1:0] ex_dst;
  logic                      ex_we;
  logic                      ex_store;
  logic                      wb_valid;
  logic                      wb_we_r;
  logic                      wb_store_r;

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////
  assign id_op   = opcode_t'(inst[op_msb:op_lsb]);
  assign rs_addr = inst[rs_msb:rs_lsb];
  assign rt_addr = inst[rt_msb:rt_lsb];
  assign imm     = inst[imm_msb:imm_lsb];

  always_comb begin
    dec_alu_op  = alu_add;
    dec_use_imm = 1'b0;
    dec_we      = 1'b0;
    dec_store   = 1'b0;
    dec_dst     = inst[rd_msb:rd_lsb];
    case (id_op)
      op_add: dec_we = 1'b1;
      op_sub: begin
        dec_alu_op = alu_sub;
        dec_we     = 1'b1;
      end
      op_and: begin
        dec_alu_op = alu_and;
        dec_we     = 1'b1;
      end
      op_or: begin
        dec_alu_op = alu_or;
        dec_we     = 1'b1;
      end
      op_xor: begin
        dec_alu_op = alu_xor;
        dec_we     = 1'b1;
      end
      op_slt: begin
        dec_alu_op = alu_slt;
        dec_we     = 1'b1;
      end
      op_addi: begin
        dec_use_imm = 1'b1;
        dec_we      = 1'b1;
        dec_dst     = inst[rt_msb:rt_lsb];
      end
      // address is rs + imm
      op_sw: begin
        dec_use_imm = 1'b1;
        dec_store   = 1'b1;
      end
      default: ;
    endcase
  end

  // whole pipe waits on an outstanding store
  assign advance = !(wb_is_store && !store_done);
  assign take    = inst_valid && advance;

  ////////////////////////////////////////////////////////////
  // EX and WB stage registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid   <= 1'b0;
      ex_rs      <= '0;
      ex_rt      <= '0;
      ex_dst     <= '0;
      ex_we      <= 1'b0;
      ex_store   <= 1'b0;
      alu_op     <= alu_add;
      use_imm    <= 1'b0;
      wb_valid   <= 1'b0;
      wb_rd      <= '0;
      wb_we_r    <= 1'b0;
      wb_store_r <= 1'b0;
    end else if (advance) begin
      ex_valid   <= inst_valid;
      ex_rs      <= rs_addr;
      ex_rt      <= rt_addr;
      ex_dst     <= dec_dst;
      ex_we      <= inst_valid && dec_we;
      ex_store   <= inst_valid && dec_store;
      alu_op     <= dec_alu_op;
      use_imm    <= dec_use_imm;
      wb_valid   <= ex_valid;
      wb_rd      <= ex_dst;
      wb_we_r    <= ex_we;
      wb_store_r <= ex_store;
    end
  end

  assign wb_we       = wb_valid && wb_we_r;
  assign wb_is_store = wb_valid && wb_store_r;

  // WB result into EX but never for r0
  assign fwd_a = (wb_we && wb_rd != '0 && wb_rd == ex_rs) ? fwd_wb : fwd_reg;
  assign fwd_b = (wb_we && wb_rd != '0 && wb_rd == ex_rt) ? fwd_wb : fwd_reg;

  a_store_no_write : assert property (
    @(posedge clk) disable iff (!arst_n)
    !(wb_we && wb_is_store)
  );

endmodule

`default_nettype wire

/* hdl/register_file.sv */
`default_nettype none

module register_file import pipe_pkg::*; (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [reg_addr_width-1:0] rs_addr,
  input  logic [reg_addr_width-1:0] rt_addr,
  output logic [xlen-1:0]           rs_data,
  output logic [xlen-1:0]           rt_data,
  input  logic                      we,
  input  logic [reg_addr_width-1:0] wr_addr,
  input  logic [xlen-1:0]           wr_data
);

  logic [xlen-1:0] regs [num_regs];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // write-through so WB is seen by ID in the same cycle
  always_comb begin
    if (rs_addr == '0) begin
      rs_data = '0;
    end else if (we && wr_addr == rs_addr) begin
      rs_data = wr_data;
    end else begin
      rs_data = regs[rs_addr];
    end
  end

  always_comb begin
    if (rt_addr == '0) begin
      rt_data = '0;
    end else if (we && wr_addr == rt_addr) begin
      rt_data = wr_data;
    end else begin
      rt_data = regs[rt_addr];
    end
  end

endmodule

`default_nettype wire

/* hdl/execute_unit.sv */
`default_nettype none

module execute_unit import pipe_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 advance,
  input  logic [xlen-1:0]      rs_data,
  input  logic [xlen-1:0]      rt_data,
  input  alu_op_t              alu_op,
  input  logic                 use_imm,
  input  logic [imm_width-1:0] imm,
  input  fwd_sel_t             fwd_a,
  input  fwd_sel_t             fwd_b,
  output logic [xlen-1:0]      wb_result,
  output logic [xlen-1:0]      store_adr,
  output logic [xlen-1:0]      store_dat
);

  logic [xlen-1:0]      ex_a;
  logic [xlen-1:0]      ex_b;
  logic [imm_width-1:0] ex_imm;
  logic [xlen-1:0]      op_a;
  logic [xlen-1:0]      op_b;
  logic [xlen-1:0]      alu_b;
  logic [xlen-1:0]      alu_res;

  ////////////////////////////////////////////////////////////
  // ID/EX operands
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_a   <= '0;
      ex_b   <= '0;
      ex_imm <= '0;
    end else if (advance) begin
      ex_a   <= rs_data;
      ex_b   <= rt_data;
      ex_imm <= imm;
    end
  end

  // forward muxes
  assign op_a = (fwd_a == fwd_wb) ? wb_result : ex_a;
  assign op_b = (fwd_b == fwd_wb) ? wb_result : ex_b;

  // immediate is zero-extended
  assign alu_b = use_imm ? {{(xlen-imm_width){1'b0}}, ex_imm} : op_b;

  always_comb begin
    case (alu_op)
      alu_add: alu_res = op_a + alu_b;
      alu_sub: alu_res = op_a - alu_b;
      alu_and: alu_res = op_a & alu_b;
      alu_or:  alu_res = op_a | alu_b;
      alu_xor: alu_res = op_a ^ alu_b;
      alu_slt: alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      default: alu_res = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // EX/WB result
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_result <= '0;
      store_dat <= '0;
    end else if (advance) begin
      wb_result <= alu_res;
      store_dat <= op_b;
    end
  end

  // store address comes out of the ALU as rs + imm
  assign store_adr = wb_result;

endmodule

`default_nettype wire

/* hdl/store_unit.sv */
`default_nettype none

module store_unit import pipe_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            wb_is_store,
  input  logic [xlen-1:0] store_adr,
  input  logic [xlen-1:0] store_dat,
  output logic            dbus_cyc,
  output logic            dbus_stb,
  output logic            dbus_we,
  output logic [xlen-1:0] dbus_adr,
  output logic [xlen-1:0] dbus_dat_o,
  input  logic            dbus_ack,
  output logic            store_done
);

  typedef enum logic {
    st_idle,
    st_busy
  } state_t;

  state_t state;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (wb_is_store) state <= st_busy;
        st_busy: if (dbus_ack) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  assign dbus_cyc = (state == st_busy);
  assign dbus_stb = dbus_cyc;
  assign dbus_we  = dbus_cyc;

  // address and data hold while the pipe is frozen
  assign dbus_adr   = store_adr;
  assign dbus_dat_o = store_dat;

  assign store_done = dbus_cyc && dbus_ack;

  a_stb_in_store : assert property (
    @(posedge clk) disable iff (!arst_n)
    dbus_stb |-> dbus_cyc && dbus_we && wb_is_store
  );

  a_payload_stable : assert property (
    @(posedge clk) disable iff (!arst_n)
    dbus_stb && !dbus_ack |=> $stable(dbus_adr) && $stable(dbus_dat_o)
  );

endmodule

`default_nettype wire

/* hdl/core_top.sv */
`default_nettype none

module core_top import pipe_pkg::*; #(
  parameter logic [xlen-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            arst_n,
  // instruction bus
  output logic            ibus_cyc,
  output logic            ibus_stb,
  output logic [xlen-1:0] ibus_adr,
  input  logic            ibus_ack,
  input  inst_t           ibus_dat_i,
  // data bus for stores only
  output logic            dbus_cyc,
  output logic            dbus_stb,
  output logic            dbus_we,
  output logic [xlen-1:0] dbus_adr,
  output logic [xlen-1:0] dbus_dat_o,
  input  logic            dbus_ack
);

  inst_t                     inst;
  logic                      inst_valid;
  logic                      take;
  logic [reg_addr_width-1:0] rs_addr;
  logic [reg_addr_width-1:0] rt_addr;
  logic [xlen-1:0]           rs_data;
  logic [xlen-1:0]           rt_data;
  alu_op_t                   alu_op;
  logic                      use_imm;
  logic [imm_width-1:0]      imm;
  fwd_sel_t                  fwd_a;
  fwd_sel_t                  fwd_b;
  logic                      advance;
  logic [reg_addr_width-1:0] wb_rd;
  logic                      wb_we;
  logic                      wb_is_store;
  logic [xlen-1:0]           wb_result;
  logic [xlen-1:0]           store_adr;
  logic [xlen-1:0]           store_dat;
  logic                      store_done;

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) i_fetch_unit (
    .clk        (clk),
    .arst_n     (arst_n),
    .ibus_cyc   (ibus_cyc),
    .ibus_stb   (ibus_stb),
    .ibus_adr   (ibus_adr),
    .ibus_ack   (ibus_ack),
    .ibus_dat_i (ibus_dat_i),
    .take       (take),
    .inst       (inst),
    .inst_valid (inst_valid)
  );

  pipe_control i_pipe_control (
    .clk         (clk),
    .arst_n      (arst_n),
    .inst        (inst),
    .inst_valid  (inst_valid),
    .store_done  (store_done),
    .take        (take),
    .rs_addr     (rs_addr),
    .rt_addr     (rt_addr),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .imm         (imm),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b),
    .advance     (advance),
    .wb_rd       (wb_rd),
    .wb_we       (wb_we),
    .wb_is_store (wb_is_store)
  );

  register_file i_register_file (
    .clk     (clk),
    .arst_n  (arst_n),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .we      (wb_we),
    .wr_addr (wb_rd),
    .wr_data (wb_result)
  );

  execute_unit i_execute_unit (
    .clk       (clk),
    .arst_n    (arst_n),
    .advance   (advance),
    .rs_data   (rs_data),
    .rt_data   (rt_data),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .imm       (imm),
    .fwd_a     (fwd_a),
    .fwd_b     (fwd_b),
    .wb_result (wb_result),
    .store_adr (store_adr),
    .store_dat (store_dat)
  );

  store_unit i_store_unit (
    .clk         (clk),
    .arst_n      (arst_n),
    .wb_is_store (wb_is_store),
    .store_adr   (store_adr),
    .store_dat   (store_dat),
    .dbus_cyc    (dbus_cyc),
    .dbus_stb    (dbus_stb),
    .dbus_we     (dbus_we),
    .dbus_adr    (dbus_adr),
    .dbus_dat_o  (dbus_dat_o),
    .dbus_ack    (dbus_ack),
    .store_done  (store_done)
  );

endmodule

`default_nettype wire

/* test/core_tb.sv */
`default_nettype none

module core_tb import pipe_pkg::*; ();

  logic            clk;
  logic            arst_n;
  logic            ibus_cyc;
  logic            ibus_stb;
  logic [xlen-1:0] ibus_adr;
  logic            ibus_ack;
  inst_t           ibus_dat_i;
  logic            dbus_cyc;
  logic            dbus_stb;
  logic            dbus_we;
  logic [xlen-1:0] dbus_adr;
  logic [xlen-1:0] dbus_dat_o;
  logic            dbus_ack;

  int              seed;
  int              ibus_wait;
  int              dbus_wait;
  int              value_errors;
  int              other_errors;
  int              stores_seen;
  bit              prog_loaded;
  logic [xlen-1:0] exp_fetch_adr;

  // program table and the stores it should produce
  inst_t           prog_inst [$];
  string           prog_name [$];
  logic [xlen-1:0] exp_adr [$];
  logic [xlen-1:0] exp_dat [$];
  string           exp_name [$];

  core_top i_core_top (
    .clk        (clk),
    .arst_n     (arst_n),
    .ibus_cyc   (ibus_cyc),
    .ibus_stb   (ibus_stb),
    .ibus_adr   (ibus_adr),
    .ibus_ack   (ibus_ack),
    .ibus_dat_i (ibus_dat_i),
    .dbus_cyc   (dbus_cyc),
    .dbus_stb   (dbus_stb),
    .dbus_we    (dbus_we),
    .dbus_adr   (dbus_adr),
    .dbus_dat_o (dbus_dat_o),
    .dbus_ack   (dbus_ack)
  );

  always #2 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  function automatic inst_t enc_r(input logic [5:0] op, input int rs, input int rt,
                                  input int rd);
    return {op, 5'(rs), 5'(rt), 5'(rd), 11'd0};
  endfunction

  function automatic inst_t enc_i(input logic [5:0] op, input int rs, input int rt,
                                  input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  task automatic add_row(input inst_t word, input string name);
    prog_inst.push_back(word);
    prog_name.push_back(name);
  endtask

  ////////////////////////////////////////////////////////////
  // program
  ////////////////////////////////////////////////////////////
  task automatic load_program();
    add_row(enc_i(op_addi, 0, 1, 16'h1234), "addi_small");
    add_row(enc_i(op_addi, 0, 2, 16'hfff0), "addi_zext");
    add_row(enc_r(op_add, 1, 2, 3), "add_dist1_dist2");
    add_row(enc_i(op_sw, 0, 3, 16'h0100), "sw_add");
    add_row(enc_r(op_sub, 1, 2, 4), "sub");
    add_row(enc_i(op_sw, 0, 4, 16'h0104), "sw_sub");
    add_row(enc_r(op_and, 1, 2, 5), "and");
    add_row(enc_i(op_sw, 0, 5, 16'h0108), "sw_and");
    add_row(enc_r(op_or, 1, 2, 6), "or");
    add_row(enc_i(op_sw, 0, 6, 16'h010c), "sw_or");
    add_row(enc_r(op_xor, 1, 2, 7), "xor");
    add_row(enc_i(op_sw, 0, 7, 16'h0110), "sw_xor");
    add_row(enc_r(op_slt, 4, 1, 8), "slt_true");
    add_row(enc_r(op_slt, 1, 4, 9), "slt_false");
    add_row(enc_i(op_sw, 0, 8, 16'h0114), "sw_slt_true");
    add_row(enc_i(op_sw, 0, 9, 16'h0118), "sw_slt_false");
    add_row(enc_i(op_addi, 1, 0, 16'h0055), "addi_to_r0");
    add_row(enc_i(op_sw, 1, 0, 16'h011c), "sw_r0");
    add_row(enc_r(op_add, 0, 1, 10), "add_r0_src");
    add_row(enc_i(op_sw, 0, 10, 16'h0120), "sw_r0_src");
    add_row(enc_r(6'h3f, 1, 1, 11), "unknown_op");
    add_row(enc_i(op_sw, 0, 11, 16'h0124), "sw_unknown");
    add_row(enc_i(op_addi, 3, 12, 16'h0008), "addi_chain_a");
    add_row(enc_i(op_addi, 12, 12, 16'h0010), "addi_chain_b");
    add_row(enc_i(op_sw, 12, 12, 16'h0000), "sw_fwd_base");
    add_row(enc_r(op_xor, 12, 1, 13), "xor_late");
    add_row(enc_i(op_sw, 12, 13, 16'h0200), "sw_fwd_data");
  endtask

  // walk the table with a register model
  task automatic predict_stores();
    logic [31:0] model [32];
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] zimm;
    for (int r = 0; r < 32; r++) begin
      model[r] = '0;
    end
    for (int i = 0; i < prog_inst.size(); i++) begin
      op   = prog_inst[i][31:26];
      rs   = prog_inst[i][25:21];
      rt   = prog_inst[i][20:16];
      rd   = prog_inst[i][15:11];
      a    = model[rs];
      b    = model[rt];
      zimm = {16'd0, prog_inst[i][15:0]};
      case (op)
        op_add:  model[rd] = a + b;
        op_sub:  model[rd] = a - b;
        op_and:  model[rd] = a & b;
        op_or:   model[rd] = a | b;
        op_xor:  model[rd] = a ^ b;
        op_slt:  model[rd] = {31'd0, $signed(a) < $signed(b)};
        op_addi: model[rt] = a + zimm;
        op_sw: begin
          exp_adr.push_back(a + zimm);
          exp_dat.push_back(b);
          exp_name.push_back(prog_name[i]);
        end
        default: ;
      endcase
      // r0 stays zero
      model[0] = '0;
    end
  endtask

  function automatic inst_t fetch_word(input logic [31:0] adr);
    int row;
    row = int'(adr >> 2);
    if (row < prog_inst.size()) begin
      return prog_inst[row];
    end
    return {op_nop, 26'd0};
  endfunction

  ////////////////////////////////////////////////////////////
  // bus models
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (ibus_ack) begin
      ibus_ack <= 1'b0;
    end else if (ibus_cyc && ibus_stb) begin
      if (ibus_wait > 0) begin
        ibus_wait <= ibus_wait - 1;
      end else begin
        check_value("fetch_adr", exp_fetch_adr, ibus_adr);
        exp_fetch_adr <= exp_fetch_adr + 32'd4;
        ibus_dat_i    <= fetch_word(ibus_adr);
        ibus_ack      <= 1'b1;
        ibus_wait     <= $random(seed) & 3;
      end
    end
  end

  task automatic take_store();
    if (stores_seen < exp_adr.size()) begin
      check_value({exp_name[stores_seen], " adr"}, exp_adr[stores_seen], dbus_adr);
      check_value({exp_name[stores_seen], " dat"}, exp_dat[stores_seen], dbus_dat_o);
      check_value({exp_name[stores_seen], " we"}, 32'd1, {31'd0, dbus_we});
    end else begin
      other_errors++;
      $display("unexpected extra store of %h to address %h", dbus_dat_o, dbus_adr);
    end
    stores_seen++;
  endtask

  always @(posedge clk) begin
    if (dbus_ack) begin
      dbus_ack <= 1'b0;
    end else if (dbus_cyc && dbus_stb) begin
      if (dbus_wait > 0) begin
        dbus_wait <= dbus_wait - 1;
      end else begin
        take_store();
        dbus_ack  <= 1'b1;
        dbus_wait <= $random(seed) & 3;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////
  initial begin
    clk           = 1'b0;
    arst_n        = 1'b0;
    ibus_ack      = 1'b0;
    ibus_dat_i    = '0;
    dbus_ack      = 1'b0;
    seed          = 16561;
    value_errors  = 0;
    other_errors  = 0;
    stores_seen   = 0;
    exp_fetch_adr = '0;
    ibus_wait     = $random(seed) & 3;
    dbus_wait     = $random(seed) & 3;
    load_program();
    predict_stores();
    prog_loaded = 1'b1;
    repeat (10) @(posedge clk);
    check_value("reset_ibus_cyc", 32'd0, {31'd0, ibus_cyc});
    check_value("reset_ibus_stb", 32'd0, {31'd0, ibus_stb});
    check_value("reset_dbus_cyc", 32'd0, {31'd0, dbus_cyc});
    check_value("reset_dbus_stb", 32'd0, {31'd0, dbus_stb});
    arst_n <= 1'b1;
    wait (stores_seen >= exp_adr.size());
    // any store during the trailing nops is an extra one
    repeat (20) @(posedge clk);
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    wait (prog_loaded);
    repeat (prog_inst.size() * 20 + 100) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles, %0d of %0d stores seen",
             prog_inst.size() * 20 + 100, stores_seen, exp_adr.size());
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hdl/pipe_pkg.sv
hdl/fetch_unit.sv
hdl/pipe_control.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/store_unit.sv
hdl/core_top.sv
test/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= core_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
